// File: compile.f
rv_pkg.sv
rv_issue_if.sv
rv_fetch.sv
rv_decode.sv
rv_regs.sv
rv_alu.sv
rv_ctrl.sv
rv_core.sv
tb_rv_core_asserts.sv
tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_rv_core -f compile.f -o tb_rv_core_sim \
    && ./obj_dir/tb_rv_core_sim 2>&1 | tee sim.log \
    && ! grep -q "TEST RESULT: FAIL" sim.log \
    && grep -q "TEST RESULT: PASS" sim.log \
    || { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int          PROG_LEN   = 64;
    localparam logic [15:0] LFSR_POLY  = 16'hB400;
    localparam logic [15:0] LFSR_SEED  = 16'd38406;
    localparam int          TIMEOUT_NS = PROG_LEN * 10 * 20; // ten cycles of 20 ns per instruction.
    localparam int          T_ALU      = 0;
    localparam int          T_X0       = 1;
    localparam int          T_BAD      = 2;
    localparam int          T_TIMING   = 3;

    logic        clk;
    logic        arst_n;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [2:0]  arprot;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [15:0] lfsr = LFSR_SEED;
    logic [31:0] prog [PROG_LEN];
    logic        slverr [PROG_LEN];
    logic [31:0] model_regs [32] = '{default: '0};
    logic        started = 1'b0;
    int          cyc = 0;
    int          retired = 0;
    int          fetched = 0;
    int          fetch_errs = 0;
    int          reset_errs = 0;
    int          r_cycles [$];
    int          checks [4] = '{default: 0};
    int          errors [4] = '{default: 0};
    string       test_name [4] = '{"alu_program", "x0_write", "bad_fetch", "retire_timing"};

    rv_core i_dut
    (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .o_arvalid      (arvalid),
        .i_arready      (arready),
        .o_araddr       (araddr),
        .o_arprot       (arprot),
        .i_rvalid       (rvalid),
        .o_rready       (rready),
        .i_rdata        (rdata),
        .i_rresp        (rresp),
        .o_retire_valid (retire_valid),
        .o_retire_rd    (retire_rd),
        .o_retire_data  (retire_data)
    );

    bind rv_core tb_rv_core_asserts u_asserts
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_arvalid      (o_arvalid),
        .i_arready      (i_arready),
        .i_araddr       (o_araddr),
        .i_rvalid       (i_rvalid),
        .i_rready       (o_rready),
        .i_retire_valid (o_retire_valid)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] make_instr();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [11:0] imm;
        kind = 3'(rand_bits(3));
        f3   = 3'(rand_bits(3));
        rd   = 5'(rand_bits(3)); // only x0 to x7, so neighbours often depend on each other.
        rs1  = 5'(rand_bits(3));
        rs2  = 5'(rand_bits(3));
        alt  = 1'(rand_bits(1));
        imm  = 12'(rand_bits(12));
        if (kind < 3'd3)
            return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0000000,
                    rs2, rs1, f3, rd, rv_pkg::OPC_OP};
        if (kind < 3'd6)
        begin
            // shift immediates carry only a shift amount and the arithmetic bit.
            if (f3 == 3'd1 || f3 == 3'd5)
                imm = {1'b0, alt && f3 == 3'd5, 5'b00000, imm[4:0]};
            return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
        end
        if (kind == 3'd6)
            return {imm, rs2, f3, rd, rv_pkg::OPC_LUI};
        return {imm, rs1, f3, rd, 7'b0000011}; // a load, which this core does not execute.
    endfunction

    function automatic logic is_known(input logic [31:0] w);
        return (w[6:0] == rv_pkg::OPC_OP) || (w[6:0] == rv_pkg::OPC_OP_IMM) ||
               (w[6:0] == rv_pkg::OPC_LUI);
    endfunction

    // executes one instruction as the ISA defines it and returns {rd, data}.
    function automatic logic [36:0] ref_exec(input logic [31:0] w, input logic ok);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        is_op;
        rd    = w[11:7];
        a     = model_regs[w[19:15]];
        is_op = (w[6:0] == rv_pkg::OPC_OP);
        b     = is_op ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        if (!ok || !is_known(w))
            return 37'b0;
        if (w[6:0] == rv_pkg::OPC_LUI)
            res = {w[31:12], 12'b0};
        else
        begin
            case (w[14:12])
                3'd0:    res = (is_op && w[30]) ? a - b : a + b;
                3'd1:    res = a << b[4:0];
                3'd2:    res = {31'b0, $signed(a) < $signed(b)};
                3'd3:    res = {31'b0, a < b};
                3'd4:    res = a ^ b;
                3'd5:
                begin
                    if (w[30])
                        res = $signed(a) >>> b[4:0];
                    else
                        res = a >> b[4:0];
                end
                3'd6:    res = a | b;
                default: res = a & b;
            endcase
        end
        if (rd != 5'd0)
            model_regs[rd] = res;
        return {rd, res};
    endfunction

    function automatic int test_for_instr(input logic [31:0] w, input logic err);
        if (err || !is_known(w))
            return T_BAD;
        if (w[11:7] == 5'd0)
            return T_X0;
        return T_ALU;
    endfunction

    task automatic report_test(input string name, input int n_checks, input int n_errs);
        $display("%s: %0d checks, %0d errors", name, n_checks, n_errs);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    initial
    begin
        int total_checks;
        int total_errs;
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        assert (arvalid === 1'b1 && araddr === 32'h0 && retire_valid === 1'b0)
        else
        begin
            reset_errs++;
            $display("mismatch reset_state: expected arvalid 1 araddr 00000000 retire 0, %s",
                     $sformatf("actual arvalid %b araddr %08h retire %b",
                               arvalid, araddr, retire_valid));
        end
        report_test("reset_state", 1, reset_errs);
        started = 1'b1;
        wait (retired == PROG_LEN);
        @(negedge clk);
        report_test("fetch_addr", fetched, fetch_errs);
        total_checks = 1 + fetched;
        total_errs   = reset_errs + fetch_errs;
        for (int t = 0; t < 4; t++)
        begin
            report_test(test_name[t], checks[t], errors[t]);
            total_checks += checks[t];
            total_errs   += errors[t];
        end
        $display("all tests: %0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // the memory model is a single AXI4-Lite read slave with random AR and R delays.
    initial
    begin
        logic [31:0] addr;
        logic [2:0]  prot;
        int          idx;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        for (int k = 0; k < PROG_LEN; k++)
        begin
            prog[k]   = make_instr();
            slverr[k] = (k % 11 == 5);
        end
        wait (started);
        forever
        begin
            while (!arvalid)
                @(negedge clk);
            repeat (rand_bits(2)) @(negedge clk);
            addr    = araddr;
            prot    = arprot;
            arready = 1'b1;
            @(negedge clk);
            arready = 1'b0;
            assert (addr == 32'(fetched * 4))
            else
            begin
                fetch_errs++;
                $display("mismatch fetch_addr: expected %08h, actual %08h", fetched * 4, addr);
            end
            // an instruction fetch goes out as an unprivileged data access.
            assert (prot === 3'b000)
            else
            begin
                fetch_errs++;
                $display("mismatch fetch_addr: expected arprot 000, actual %03b", prot);
            end
            fetched++;
            idx = int'(addr >> 2);
            repeat (rand_bits(2)) @(negedge clk);
            rdata  = (idx < PROG_LEN) ? prog[idx] : 32'h0;
            rresp  = (idx < PROG_LEN && slverr[idx]) ? 2'b10 : 2'b00;
            rvalid = 1'b1;
            @(negedge clk);
            rvalid = 1'b0;
            r_cycles.push_back(cyc); // the edge on which the R handshake took place.
        end
    end

    always @(negedge clk)
    begin
        logic [36:0] exp_v;
        int          t;
        int          r_at;
        if (arst_n && retire_valid && retired < PROG_LEN)
        begin
            exp_v = ref_exec(prog[retired], !slverr[retired]);
            t     = test_for_instr(prog[retired], slverr[retired]);
            checks[t]++;
            assert ({retire_rd, retire_data} == exp_v)
            else
            begin
                errors[t]++;
                $display("mismatch %s: instr %0d expected rd %0d data %08h, actual rd %0d data %08h",
                         test_name[t], retired, exp_v[36:32], exp_v[31:0], retire_rd, retire_data);
            end
            r_at = (r_cycles.size() > 0) ? r_cycles.pop_front() : -100;
            checks[T_TIMING]++;
            assert (cyc - r_at == 2)
            else
            begin
                errors[T_TIMING]++;
                $display("instr %0d retired %0d edges after its read data instead of 2",
                         retired, cyc - r_at);
            end
            retired++;
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog expired with %0d of %0d instructions retired", retired, PROG_LEN);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb_rv_core_asserts.sv
`timescale 1ns/1ps

module tb_rv_core_asserts
(
    input logic        i_clk,
    input logic        i_arst_n,
    input logic        i_arvalid,
    input logic        i_arready,
    input logic [31:0] i_araddr,
    input logic        i_rvalid,
    input logic        i_rready,
    input logic        i_retire_valid
);

    // a read address holds still until the slave takes it.
    ar_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
        else $error("read address dropped or changed before arready");

    r_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_rready && !i_rvalid |=> i_rready)
        else $error("rready dropped before read data arrived");

    one_read: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_arvalid && i_rready))
        else $error("a new read address was issued while data was still pending");

    retire_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_retire_valid |=> !i_retire_valid)
        else $error("retire valid stayed high for more than one cycle");

    // retire valid is first sampled one edge after the execute edge.
    retire_after_r: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_retire_valid |-> $past(i_rready && i_rvalid, 3))
        else $error("retire without a read handshake two edges earlier");

endmodule

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    output logic                        o_arvalid,
    input  logic                        i_arready,
    output logic [rv_pkg::ADDR_W-1:0]   o_araddr,
    output logic [2:0]                  o_arprot,
    input  logic                        i_rvalid,
    output logic                        o_rready,
    input  logic [rv_pkg::XLEN-1:0]     i_rdata,
    input  logic [1:0]                  i_rresp,
    output logic                        o_retire_valid,
    output logic [rv_pkg::REG_AW-1:0]   o_retire_rd,
    output logic [rv_pkg::XLEN-1:0]     o_retire_data
);

    logic                       fetch_en;
    logic                       fetch_done;
    logic                       instr_valid;
    rv_pkg::rv_instr_u          instr;
    logic                       instr_ok;
    logic [rv_pkg::REG_AW-1:0]  dec_rs1;
    logic [rv_pkg::REG_AW-1:0]  dec_rs2;
    logic [rv_pkg::XLEN-1:0]    rs1_data;
    logic [rv_pkg::XLEN-1:0]    rs2_data;
    logic                       fwd_a;
    logic                       fwd_b;
    logic                       wb_we;
    logic [rv_pkg::REG_AW-1:0]  wb_rd;
    logic [rv_pkg::XLEN-1:0]    wb_data;

    assign fetch_done = o_rready & i_rvalid;

    rv_issue_if u_issue ();

    rv_fetch u_fetch
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_fetch_en     (fetch_en),
        .o_arvalid      (o_arvalid),
        .i_arready      (i_arready),
        .o_araddr       (o_araddr),
        .o_arprot       (o_arprot),
        .i_rvalid       (i_rvalid),
        .o_rready       (o_rready),
        .i_rdata        (i_rdata),
        .i_rresp        (i_rresp),
        .o_instr_valid  (instr_valid),
        .o_instr        (instr),
        .o_instr_ok     (instr_ok)
    );

    rv_decode u_decode
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_instr_valid  (instr_valid),
        .i_instr        (instr),
        .i_instr_ok     (instr_ok),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_fwd_a        (fwd_a),
        .i_fwd_b        (fwd_b),
        .i_fwd_data     (wb_data),
        .o_rs1          (dec_rs1),
        .o_rs2          (dec_rs2),
        .issue          (u_issue.src)
    );

    rv_regs u_regs
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_rs1          (dec_rs1),
        .i_rs2          (dec_rs2),
        .i_rd           (wb_rd),
        .i_we           (wb_we),
        .i_wdata        (wb_data),
        .o_rs1_data     (rs1_data),
        .o_rs2_data     (rs2_data)
    );

    rv_alu u_alu
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .issue          (u_issue.dst),
        .o_wb_we        (wb_we),
        .o_wb_rd        (wb_rd),
        .o_wb_data      (wb_data),
        .o_retire_valid (o_retire_valid),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data)
    );

    rv_ctrl u_ctrl
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_fetch_done   (fetch_done),
        .i_dec_rs1      (dec_rs1),
        .i_dec_rs2      (dec_rs2),
        .i_ex_rd        (wb_rd),
        .i_ex_we        (wb_we),
        .o_fetch_en     (fetch_en),
        .o_fwd_a        (fwd_a),
        .o_fwd_b        (fwd_b)
    );

endmodule

// File: rv_ctrl.sv
`timescale 1ns/1ps

module rv_ctrl
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_fetch_done,
    input  logic [rv_pkg::REG_AW-1:0]   i_dec_rs1,
    input  logic [rv_pkg::REG_AW-1:0]   i_dec_rs2,
    input  logic [rv_pkg::REG_AW-1:0]   i_ex_rd,
    input  logic                        i_ex_we,
    output logic                        o_fetch_en,
    output logic                        o_fwd_a,
    output logic                        o_fwd_b
);

    logic dec_live;
    logic ex_live;
    logic ex_writes;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            dec_live <= 1'b0;
            ex_live  <= 1'b0;
        end
        else
        begin
            dec_live <= i_fetch_done; // word sits in the fetch register for one cycle.
            ex_live  <= dec_live;
        end
    end

    // a new request may start only while nothing waits to be decoded.
    assign o_fetch_en = !dec_live;

    assign ex_writes = ex_live & i_ex_we & (i_ex_rd != '0);
    assign o_fwd_a   = ex_writes & (i_ex_rd == i_dec_rs1);
    assign o_fwd_b   = ex_writes & (i_ex_rd == i_dec_rs2);

endmodule

// File: rv_alu.sv
`timescale 1ns/1ps

module rv_alu
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    rv_issue_if.dst                     issue,
    output logic                        o_wb_we,
    output logic [rv_pkg::REG_AW-1:0]   o_wb_rd,
    output logic [rv_pkg::XLEN-1:0]     o_wb_data,
    output logic                        o_retire_valid,
    output logic [rv_pkg::REG_AW-1:0]   o_retire_rd,
    output logic [rv_pkg::XLEN-1:0]     o_retire_data
);

    logic [rv_pkg::XLEN-1:0]         a;
    logic [rv_pkg::XLEN-1:0]         b;
    logic [rv_pkg::XLEN-1:0]         result;
    logic [$clog2(rv_pkg::XLEN)-1:0] shamt;

    assign a     = issue.op_a;
    assign b     = issue.op_b;
    assign shamt = b[$clog2(rv_pkg::XLEN)-1:0];

    always_comb
    begin
        case (issue.alu_op)
            rv_pkg::ALU_ADD:    result = a + b;
            rv_pkg::ALU_SUB:    result = a - b;
            rv_pkg::ALU_AND:    result = a & b;
            rv_pkg::ALU_OR:     result = a | b;
            rv_pkg::ALU_XOR:    result = a ^ b;
            rv_pkg::ALU_SLL:    result = a << shamt;
            rv_pkg::ALU_SRL:    result = a >> shamt;
            rv_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            rv_pkg::ALU_SLT:    result = rv_pkg::XLEN'($signed(a) < $signed(b));
            rv_pkg::ALU_SLTU:   result = rv_pkg::XLEN'(a < b);
            rv_pkg::ALU_PASS_B: result = b;
            default:            result = '0;
        endcase
    end

    assign o_wb_we   = issue.valid & issue.reg_write;
    assign o_wb_rd   = issue.rd;
    assign o_wb_data = result; // also the bypass source for decode.

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_retire_valid <= 1'b0;
        else
            o_retire_valid <= issue.valid;
    end

    always_ff @(posedge i_clk)
    begin
        o_retire_rd   <= issue.rd;
        o_retire_data <= result;
    end

endmodule

// File: rv_regs.sv
`timescale 1ns/1ps

module rv_regs
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic [rv_pkg::REG_AW-1:0]   i_rs1,
    input  logic [rv_pkg::REG_AW-1:0]   i_rs2,
    input  logic [rv_pkg::REG_AW-1:0]   i_rd,
    input  logic                        i_we,
    input  logic [rv_pkg::XLEN-1:0]     i_wdata,
    output logic [rv_pkg::XLEN-1:0]     o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]     o_rs2_data
);

    logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_AW];

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 0; i < 2**rv_pkg::REG_AW; i++)
                regs[i] <= '0;
        end
        else if (i_we && i_rd != '0)
            regs[i_rd] <= i_wdata;
    end

    // x0 reads as zero.
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: rv_decode.sv
`timescale 1ns/1ps

module rv_decode
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_instr_valid,
    input  rv_pkg::rv_instr_u           i_instr,
    input  logic                        i_instr_ok,
    input  logic [rv_pkg::XLEN-1:0]     i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]     i_rs2_data,
    input  logic                        i_fwd_a,
    input  logic                        i_fwd_b,
    input  logic [rv_pkg::XLEN-1:0]     i_fwd_data,
    output logic [rv_pkg::REG_AW-1:0]   o_rs1,
    output logic [rv_pkg::REG_AW-1:0]   o_rs2,
    rv_issue_if.src                     issue
);

    logic [rv_pkg::XLEN-1:0]     rs1_val;
    logic [rv_pkg::XLEN-1:0]     rs2_val;
    logic [rv_pkg::XLEN-1:0]     imm_i;
    logic [rv_pkg::XLEN-1:0]     imm_u;
    logic [rv_pkg::XLEN-1:0]     op_a;
    logic [rv_pkg::XLEN-1:0]     op_b;
    logic [rv_pkg::ALU_OP_W-1:0] alu_op;
    logic                        supported;

    function automatic logic [rv_pkg::ALU_OP_W-1:0] alu_sel(input logic [2:0] funct3,
                                                            input logic alt);
        case (funct3)
            3'd0:    alu_sel = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'd1:    alu_sel = rv_pkg::ALU_SLL;
            3'd2:    alu_sel = rv_pkg::ALU_SLT;
            3'd3:    alu_sel = rv_pkg::ALU_SLTU;
            3'd4:    alu_sel = rv_pkg::ALU_XOR;
            3'd5:    alu_sel = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'd6:    alu_sel = rv_pkg::ALU_OR;
            default: alu_sel = rv_pkg::ALU_AND;
        endcase
    endfunction

    assign o_rs1   = i_instr.r.rs1;
    assign o_rs2   = i_instr.r.rs2;
    assign rs1_val = i_fwd_a ? i_fwd_data : i_rs1_data; // result still being written back.
    assign rs2_val = i_fwd_b ? i_fwd_data : i_rs2_data;
    assign imm_i   = {{(rv_pkg::XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};
    assign imm_u   = {i_instr.u.imm20, 12'b0};

    always_comb
    begin
        supported = 1'b1;
        op_a      = rs1_val;
        op_b      = rs2_val;
        alu_op    = rv_pkg::ALU_ADD;
        case (i_instr.r.opcode)
            rv_pkg::OPC_OP:
                alu_op = alu_sel(i_instr.r.funct3, i_instr.r.funct7[5]);
            rv_pkg::OPC_OP_IMM:
            begin
                // only srai takes bit 30 as a selector, addi has no subtract form.
                alu_op = alu_sel(i_instr.i.funct3,
                                 (i_instr.i.funct3 == 3'd5) & i_instr.i.imm12[10]);
                op_b   = imm_i;
            end
            rv_pkg::OPC_LUI:
            begin
                alu_op = rv_pkg::ALU_PASS_B;
                op_b   = imm_u;
            end
            default:
                supported = 1'b0;
        endcase
        if (!(supported & i_instr_ok))
        begin
            alu_op = rv_pkg::ALU_PASS_B;
            op_b   = '0;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            issue.valid     <= 1'b0;
            issue.reg_write <= 1'b0;
            issue.rd        <= '0;
        end
        else
        begin
            issue.valid     <= i_instr_valid;
            issue.reg_write <= i_instr_valid & supported & i_instr_ok;
            issue.rd        <= (supported & i_instr_ok) ? i_instr.r.rd : '0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        issue.alu_op <= alu_op;
        issue.op_a   <= op_a;
        issue.op_b   <= op_b;
    end

endmodule

// File: rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_fetch_en,
    output logic                        o_arvalid,
    input  logic                        i_arready,
    output logic [rv_pkg::ADDR_W-1:0]   o_araddr,
    output logic [2:0]                  o_arprot,
    input  logic                        i_rvalid,
    output logic                        o_rready,
    input  logic [rv_pkg::XLEN-1:0]     i_rdata,
    input  logic [1:0]                  i_rresp,
    output logic                        o_instr_valid,
    output rv_pkg::rv_instr_u           o_instr,
    output logic                        o_instr_ok
);

    logic [rv_pkg::ADDR_W-1:0] pc;
    logic                      r_done;

    assign r_done   = o_rready & i_rvalid;
    assign o_araddr = pc;
    assign o_arprot = 3'b000; // unprivileged data access.

    // the state is carried by arvalid and rready, both low means idle.
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_arvalid     <= 1'b1;
            o_rready      <= 1'b0;
            o_instr_valid <= 1'b0;
            pc            <= rv_pkg::RESET_ADDR;
        end
        else
        begin
            o_instr_valid <= r_done;
            if (o_arvalid & i_arready)
            begin
                o_arvalid <= 1'b0;
                o_rready  <= 1'b1;
            end
            else if (r_done)
            begin
                o_rready  <= 1'b0;
                o_arvalid <= i_fetch_en;
                pc        <= pc + rv_pkg::ADDR_W'(4);
            end
            else if (!o_arvalid && !o_rready && i_fetch_en)
                o_arvalid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (r_done)
        begin
            o_instr    <= i_rdata;
            o_instr_ok <= (i_rresp == rv_pkg::AXI_RESP_OKAY); // slverr turns into a no-op.
        end
    end

endmodule

// File: rv_issue_if.sv
`timescale 1ns/1ps

interface rv_issue_if;

    logic                          valid;
    logic [rv_pkg::REG_AW-1:0]     rd;
    logic                          reg_write;
    logic [rv_pkg::ALU_OP_W-1:0]   alu_op;
    logic [rv_pkg::XLEN-1:0]       op_a;
    logic [rv_pkg::XLEN-1:0]       op_b;

    // execute takes every valid slot, so there is no ready signal.
    modport src (output valid, rd, reg_write, alu_op, op_a, op_b);
    modport dst (input  valid, rd, reg_write, alu_op, op_a, op_b);

endinterface

// File: rv_pkg.sv
package rv_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int ADDR_W   = 32;
    localparam int ALU_OP_W = 4;

    localparam logic [ADDR_W-1:0] RESET_ADDR = '0;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10; // lui only.

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm12;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic [19:0]       imm20;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } rv_u_fmt_t;

    // all three views share rd and opcode in the low twelve bits.
    typedef union packed {
        rv_r_fmt_t r;
        rv_i_fmt_t i;
        rv_u_fmt_t u;
    } rv_instr_u;

endpackage
